/* logic/boot_pkg.sv */
`default_nettype none

package boot_pkg;

  localparam int data_w = 16;
  localparam int adr_w  = 16;

  typedef enum logic [2:0] {
    mode_dump,
    mode_lc,
    mode_acm,
    mode_sysconfig,
    mode_done
  } boot_mode_e;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } bus_op_e;

  // FROM below 0x100, local up to 0x3ff, flash from 0x400
  localparam logic [adr_w-1:0] from_acm_a        = 16'h0000;
  localparam logic [adr_w-1:0] from_lc_a         = 16'h0028;
  localparam logic [adr_w-1:0] systime_a         = 16'h0100;
  localparam logic [adr_w-1:0] crashsrc_a        = 16'h010c;
  localparam logic [adr_w-1:0] crashval_a        = 16'h010d;
  localparam logic [adr_w-1:0] lc_threshs_a      = 16'h0180;
  localparam logic [adr_w-1:0] acm_aquads_a      = 16'h0200;
  localparam logic [adr_w-1:0] vs_indirect_a     = 16'h0240;
  localparam logic [adr_w-1:0] sysconfig_a       = 16'h0241;
  localparam logic [adr_w-1:0] flash_a           = 16'h0400;
  localparam logic [adr_w-1:0] flash_sysconfig_a = 16'hffff;

  localparam logic [data_w-1:0] dump_marker = 16'hdead;  // first word of a crash dump

endpackage

`default_nettype wire

/* logic/wb_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface wb_if import boot_pkg::*; ();

  logic              cyc;
  logic              stb;
  bus_op_e           we;
  logic [adr_w-1:0]  adr;
  logic [data_w-1:0] dat_m2s;
  logic [data_w-1:0] dat_s2m;
  logic              ack;
  logic              err;  // ends a cycle like ack

  modport master (output cyc, stb, we, adr, dat_m2s, input dat_s2m, ack, err);
  modport slave  (input cyc, stb, we, adr, dat_m2s, output dat_s2m, ack, err);

endinterface

`default_nettype wire

/* logic/event_ring.sv */
`timescale 1ns/1ns
`default_nettype none

module event_ring import boot_pkg::*; #(
  parameter int RING_DEPTH = 16
) (
  input  wire               wb_clk_i,
  input  wire               soft_reset,
  input  wire               freeze_i,
  input  wire               unfreeze_i,
  input  wire               push_i,
  input  wire  [data_w-2:0] push_dat_i,
  input  wire               pop_i,
  output logic [data_w-1:0] pop_dat_o
);

  localparam int ptr_w = $clog2(RING_DEPTH);
  localparam int cnt_w = $clog2(RING_DEPTH + 1);

  logic [data_w-2:0] mem [RING_DEPTH];
  logic [ptr_w-1:0]  wr_q;
  logic [ptr_w-1:0]  rd_q;
  logic [cnt_w-1:0]  cnt_q;
  logic              frozen_q;
  logic              full;
  logic              push_ok;
  logic              pop_ok;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    ptr_inc = (p == ptr_w'(RING_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (cnt_q == cnt_w'(RING_DEPTH));
  assign push_ok = push_i & ~frozen_q;
  assign pop_ok  = pop_i & (cnt_q != '0);

  // bit 15 flags the last entry, empty ring reads as flag only
  assign pop_dat_o = (cnt_q == '0) ? {1'b1, {(data_w-1){1'b0}}} :
                                     {cnt_q == cnt_w'(1), mem[rd_q]};

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      wr_q     <= '0;
      rd_q     <= '0;
      cnt_q    <= '0;
      frozen_q <= 1'b0;
    end else begin
      if (freeze_i) begin
        frozen_q <= 1'b1;
      end else if (unfreeze_i) begin
        frozen_q <= 1'b0;
      end
      if (push_ok) begin
        wr_q <= ptr_inc(wr_q);
      end
      if (pop_ok || (push_ok && full)) begin
        rd_q <= ptr_inc(rd_q);  // full ring drops its oldest
      end
      if (push_ok && !full && !pop_ok) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (push_ok) begin
      mem[wr_q] <= push_dat_i;
    end
  end

  // dumps only pop a frozen ring, so no push slips in
  a_no_push_pop: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    pop_ok |-> !push_ok);

endmodule

`default_nettype wire

/* logic/ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs import boot_pkg::*; #(
  parameter int LC_COUNT   = 64,
  parameter int ACM_COUNT  = 40,
  parameter int RING_DEPTH = 16
) (
  input  wire                          wb_clk_i,
  input  wire                          soft_reset,
  wb_if.slave                          bus,
  input  wire                          crash_i,
  input  wire  [data_w-1:0]            crash_src_i,
  input  wire  [data_w-1:0]            crash_val_i,
  input  wire                          event_vld_i,
  input  wire  [data_w-2:0]            event_dat_i,
  input  wire  [$clog2(LC_COUNT)-1:0]  lc_rd_adr_i,
  input  wire  [$clog2(ACM_COUNT)-1:0] acm_rd_adr_i,
  output logic [11:0]                  lc_thresh_o,
  output logic [data_w-1:0]            acm_quad_o,
  output logic [data_w-1:0]            sysconfig_o
);

  localparam int lc_aw  = $clog2(LC_COUNT);
  localparam int acm_aw = $clog2(ACM_COUNT);

  logic [47:0]       systime_q;
  logic              crash_d_q;
  logic [data_w-1:0] crash_src_q;
  logic [data_w-1:0] crash_val_q;
  logic [11:0]       lc_tbl [LC_COUNT];
  logic [data_w-1:0] acm_tbl [ACM_COUNT];
  logic [data_w-1:0] sysconfig_q;
  logic [data_w-1:0] rd_dat;
  logic [data_w-1:0] rdat_q;
  logic [data_w-1:0] pop_dat;
  logic [adr_w-1:0]  lc_off;
  logic [adr_w-1:0]  acm_off;
  logic              lc_hit;
  logic              acm_hit;
  logic              hit;
  logic              ack_q;
  logic              err_q;
  logic              start;
  logic              wr;
  logic              ring_sel;

  assign start    = bus.cyc & bus.stb & ~ack_q & ~err_q;
  assign wr       = start & (bus.we == op_write);
  assign ring_sel = start & (bus.adr == vs_indirect_a);
  assign lc_off   = bus.adr - lc_threshs_a;
  assign acm_off  = bus.adr - acm_aquads_a;
  assign lc_hit   = (bus.adr >= lc_threshs_a) && (lc_off < adr_w'(LC_COUNT));
  assign acm_hit  = (bus.adr >= acm_aquads_a) && (acm_off < adr_w'(ACM_COUNT));

  assign bus.ack     = ack_q;
  assign bus.err     = err_q;
  assign bus.dat_s2m = rdat_q;

  assign lc_thresh_o = lc_tbl[lc_rd_adr_i];
  assign acm_quad_o  = acm_tbl[acm_rd_adr_i];
  assign sysconfig_o = sysconfig_q;

  always_comb begin
    hit    = 1'b1;
    rd_dat = '0;
    if (lc_hit) begin
      rd_dat = data_w'(lc_tbl[lc_off[lc_aw-1:0]]);
    end else if (acm_hit) begin
      rd_dat = acm_tbl[acm_off[acm_aw-1:0]];
    end else begin
      case (bus.adr)
        systime_a:          rd_dat = systime_q[15:0];  // low word first
        systime_a + 16'd1:  rd_dat = systime_q[31:16];
        systime_a + 16'd2:  rd_dat = systime_q[47:32];
        crashsrc_a:         rd_dat = crash_src_q;
        crashval_a:         rd_dat = crash_val_q;
        vs_indirect_a:      rd_dat = pop_dat;
        sysconfig_a:        rd_dat = sysconfig_q;
        default:            hit = 1'b0;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      systime_q   <= '0;
      crash_d_q   <= 1'b0;
      crash_src_q <= '0;
      crash_val_q <= '0;
      sysconfig_q <= '0;
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      for (int i = 0; i < LC_COUNT; i++) begin
        lc_tbl[i] <= '0;
      end
      for (int i = 0; i < ACM_COUNT; i++) begin
        acm_tbl[i] <= '0;
      end
    end else begin
      systime_q <= systime_q + 48'd1;
      crash_d_q <= crash_i;
      if (crash_i && !crash_d_q) begin  // rising edge
        crash_src_q <= crash_src_i;
        crash_val_q <= crash_val_i;
      end
      ack_q <= start & hit;
      err_q <= start & ~hit;
      if (wr && lc_hit) begin
        lc_tbl[lc_off[lc_aw-1:0]] <= bus.dat_m2s[11:0];
      end
      if (wr && acm_hit) begin
        acm_tbl[acm_off[acm_aw-1:0]] <= bus.dat_m2s;
      end
      if (wr && bus.adr == sysconfig_a) begin
        sysconfig_q <= bus.dat_m2s;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      rdat_q <= rd_dat;
    end
  end

  event_ring #(
    .RING_DEPTH (RING_DEPTH)
  ) u_ring (
    .wb_clk_i   (wb_clk_i),
    .soft_reset (soft_reset),
    .freeze_i   (ring_sel & wr & (bus.dat_m2s == 16'h0000)),
    .unfreeze_i (ring_sel & wr & (bus.dat_m2s == 16'hffff)),
    .push_i     (event_vld_i),
    .push_dat_i (event_dat_i),
    .pop_i      (ring_sel & (bus.we == op_read)),
    .pop_dat_o  (pop_dat)
  );

endmodule

`default_nettype wire

/* logic/dma_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_engine import boot_pkg::*; #(
  parameter int LC_COUNT   = 64,
  parameter int ACM_COUNT  = 40,
  parameter int RING_DEPTH = 16
) (
  input  wire  wb_clk_i,
  input  wire  soft_reset,
  input  wire  start_i,
  input  wire  crash_i,
  output logic done_o,
  wb_if.master bus
);

  localparam int max_cnt = (LC_COUNT > ACM_COUNT) ? LC_COUNT : ACM_COUNT;
  localparam int item_w  = $clog2((max_cnt > RING_DEPTH) ? max_cnt : RING_DEPTH);

  boot_mode_e        mode_q;
  logic [3:0]        step_q;
  logic [3:0]        hdr_step;
  logic [item_w-1:0] item_q;
  logic              last_item;
  logic              cyc_q;
  bus_op_e           we_q;
  bus_op_e           nxt_we;
  logic [adr_w-1:0]  adr_q;
  logic [adr_w-1:0]  nxt_adr;
  logic [data_w-1:0] dat_q;
  logic [data_w-1:0] nxt_dat;
  logic [data_w-1:0] rdat_q;

  assign bus.cyc     = cyc_q;
  assign bus.stb     = cyc_q;
  assign bus.we      = we_q;
  assign bus.adr     = adr_q;
  assign bus.dat_m2s = dat_q;
  assign done_o      = (mode_q == mode_done);

  assign hdr_step  = step_q - 4'd2;  // header pairs start at step 2
  assign last_item = (mode_q == mode_lc) ? (item_q == item_w'(LC_COUNT - 1)) :
                                           (item_q == item_w'(ACM_COUNT - 1));

  // source of header word k: three time words, then crash source and value
  function automatic logic [adr_w-1:0] hdr_src(input logic [2:0] k);
    case (k)
      3'd3:    hdr_src = crashsrc_a;
      3'd4:    hdr_src = crashval_a;
      default: hdr_src = systime_a + adr_w'(k);
    endcase
  endfunction

  // next bus cycle, from phase and step
  always_comb begin
    nxt_we  = op_write;
    nxt_adr = flash_a;
    nxt_dat = rdat_q;
    case (mode_q)
      mode_dump: begin
        if (step_q == 4'd0) begin
          nxt_adr = vs_indirect_a;  // freeze ring
          nxt_dat = '0;
        end else if (step_q == 4'd1) begin
          nxt_dat = dump_marker;
        end else if (step_q <= 4'd11 && !step_q[0]) begin
          nxt_we  = op_read;
          nxt_adr = hdr_src(hdr_step[3:1]);
        end else if (step_q <= 4'd11) begin
          nxt_adr = flash_a + adr_w'(hdr_step[3:1] + 3'd1);
        end else if (step_q == 4'd12) begin
          nxt_we  = op_read;
          nxt_adr = vs_indirect_a;  // ring pop
        end else if (step_q == 4'd13) begin
          nxt_adr = flash_a + 16'd6 + adr_w'(item_q);
        end else begin
          nxt_adr = vs_indirect_a;  // unfreeze
          nxt_dat = 16'hffff;
        end
      end
      mode_lc: begin
        if (!step_q[0]) begin
          nxt_we  = op_read;
          nxt_adr = from_lc_a + adr_w'(item_q);
        end else begin
          nxt_adr = lc_threshs_a + adr_w'(item_q);
          nxt_dat = (rdat_q == 16'h00ff) ? 16'h0fff : rdat_q << 4;  // 0xff disables
        end
      end
      mode_acm: begin
        if (!step_q[0]) begin
          nxt_we  = op_read;
          nxt_adr = from_acm_a + adr_w'(item_q);
        end else begin
          nxt_adr = acm_aquads_a + adr_w'(item_q);
        end
      end
      default: begin
        if (!step_q[0]) begin
          nxt_we  = op_read;
          nxt_adr = flash_sysconfig_a;
        end else begin
          nxt_adr = sysconfig_a;
          nxt_dat = (rdat_q > 16'h00ff) ? '0 : rdat_q;  // blank flash reads as 0xffff
        end
      end
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      mode_q <= mode_done;
      step_q <= '0;
      item_q <= '0;
      cyc_q  <= 1'b0;
    end else if (mode_q == mode_done) begin
      if (start_i) begin
        mode_q <= crash_i ? mode_dump : mode_lc;
        step_q <= '0;
        item_q <= '0;
      end
    end else if (!cyc_q) begin
      cyc_q <= 1'b1;
      we_q  <= nxt_we;
      adr_q <= nxt_adr;
      dat_q <= nxt_dat;
    end else if (bus.ack || bus.err) begin
      cyc_q  <= 1'b0;
      step_q <= step_q + 4'd1;
      if (we_q == op_read) begin
        rdat_q <= bus.dat_s2m;
      end
      case (mode_q)
        mode_dump: begin
          if (step_q == 4'd13) begin
            if (rdat_q[15] || item_q == item_w'(RING_DEPTH - 1)) begin
              step_q <= 4'd14;
            end else begin
              step_q <= 4'd12;
              item_q <= item_q + 1'b1;
            end
          end else if (step_q == 4'd14) begin
            mode_q <= mode_lc;
            step_q <= '0;
            item_q <= '0;
          end
        end
        mode_lc, mode_acm: begin
          if (step_q[0]) begin
            step_q <= '0;
            item_q <= last_item ? '0 : item_q + 1'b1;
            if (last_item) begin
              mode_q <= (mode_q == mode_lc) ? mode_acm : mode_sysconfig;
            end
          end
        end
        mode_sysconfig: begin
          if (step_q[0]) begin
            mode_q <= mode_done;
          end
        end
        default: ;
      endcase
    end
  end

  a_ack_in_cyc: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    (bus.ack || bus.err) |-> bus.cyc);

endmodule

`default_nettype wire

/* logic/wb_addr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_addr_decoder import boot_pkg::*; (
  input  wire               wb_clk_i,
  input  wire               soft_reset,
  wb_if.slave               host,
  wb_if.master              local_bus,
  output logic              mem_cyc_o,
  output logic              mem_we_o,
  output logic [adr_w-1:0]  mem_adr_o,
  output logic [data_w-1:0] mem_dat_o,
  input  wire  [data_w-1:0] mem_dat_i,
  input  wire               mem_ack_i,
  input  wire               mem_err_i
);

  logic active_q;
  logic tgt_local_q;
  logic adr_local;

  assign adr_local = (host.adr >= systime_a) && (host.adr < flash_a);

  // target is latched once per cycle and held until ack or err
  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      active_q    <= 1'b0;
      tgt_local_q <= 1'b0;
    end else if (!active_q && host.cyc && host.stb) begin
      active_q    <= 1'b1;
      tgt_local_q <= adr_local;
    end else if (host.ack || host.err) begin
      active_q <= 1'b0;
    end
  end

  assign local_bus.cyc     = host.cyc & active_q & tgt_local_q;
  assign local_bus.stb     = host.stb & active_q & tgt_local_q;
  assign local_bus.we      = host.we;
  assign local_bus.adr     = host.adr;
  assign local_bus.dat_m2s = host.dat_m2s;

  assign mem_cyc_o = host.cyc & host.stb & active_q & ~tgt_local_q;
  assign mem_we_o  = (host.we == op_write);
  assign mem_adr_o = host.adr;
  assign mem_dat_o = host.dat_m2s;

  assign host.dat_s2m = tgt_local_q ? local_bus.dat_s2m : mem_dat_i;
  assign host.ack     = active_q & (tgt_local_q ? local_bus.ack : mem_ack_i);
  assign host.err     = active_q & (tgt_local_q ? local_bus.err : mem_err_i);

  a_one_ack: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    !(local_bus.ack && mem_ack_i));

endmodule

`default_nettype wire

/* logic/boot_loader_top.sv */
`timescale 1ns/1ns
`default_nettype none

module boot_loader_top import boot_pkg::*; #(
  parameter int LC_COUNT   = 64,
  parameter int ACM_COUNT  = 40,
  parameter int RING_DEPTH = 16
) (
  input  wire                          wb_clk_i,
  input  wire                          soft_reset,
  input  wire                          start_i,
  input  wire                          crash_i,
  output wire                          done_o,
  input  wire  [data_w-1:0]            crash_src_i,
  input  wire  [data_w-1:0]            crash_val_i,
  input  wire                          event_vld_i,
  input  wire  [data_w-2:0]            event_dat_i,
  input  wire  [$clog2(LC_COUNT)-1:0]  lc_rd_adr_i,
  input  wire  [$clog2(ACM_COUNT)-1:0] acm_rd_adr_i,
  output wire  [11:0]                  lc_thresh_o,
  output wire  [data_w-1:0]            acm_quad_o,
  output wire  [data_w-1:0]            sysconfig_o,
  output wire                          mem_cyc_o,
  output wire                          mem_we_o,
  output wire  [adr_w-1:0]             mem_adr_o,
  output wire  [data_w-1:0]            mem_dat_o,
  input  wire  [data_w-1:0]            mem_dat_i,
  input  wire                          mem_ack_i,
  input  wire                          mem_err_i
);

  wb_if eng_bus ();  // engine to decoder
  wb_if reg_bus ();  // decoder to local registers

  dma_engine #(
    .LC_COUNT   (LC_COUNT),
    .ACM_COUNT  (ACM_COUNT),
    .RING_DEPTH (RING_DEPTH)
  ) u_engine (
    .wb_clk_i   (wb_clk_i),
    .soft_reset (soft_reset),
    .start_i    (start_i),
    .crash_i    (crash_i),
    .done_o     (done_o),
    .bus        (eng_bus.master)
  );

  wb_addr_decoder u_decoder (
    .wb_clk_i   (wb_clk_i),
    .soft_reset (soft_reset),
    .host       (eng_bus.slave),
    .local_bus  (reg_bus.master),
    .mem_cyc_o  (mem_cyc_o),
    .mem_we_o   (mem_we_o),
    .mem_adr_o  (mem_adr_o),
    .mem_dat_o  (mem_dat_o),
    .mem_dat_i  (mem_dat_i),
    .mem_ack_i  (mem_ack_i),
    .mem_err_i  (mem_err_i)
  );

  ctrl_regs #(
    .LC_COUNT   (LC_COUNT),
    .ACM_COUNT  (ACM_COUNT),
    .RING_DEPTH (RING_DEPTH)
  ) u_regs (
    .wb_clk_i     (wb_clk_i),
    .soft_reset   (soft_reset),
    .bus          (reg_bus.slave),
    .crash_i      (crash_i),
    .crash_src_i  (crash_src_i),
    .crash_val_i  (crash_val_i),
    .event_vld_i  (event_vld_i),
    .event_dat_i  (event_dat_i),
    .lc_rd_adr_i  (lc_rd_adr_i),
    .acm_rd_adr_i (acm_rd_adr_i),
    .lc_thresh_o  (lc_thresh_o),
    .acm_quad_o   (acm_quad_o),
    .sysconfig_o  (sysconfig_o)
  );

endmodule

`default_nettype wire

/* sim/tb_boot_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_boot_loader import boot_pkg::*; ();

  localparam int lc_count   = 64;
  localparam int acm_count  = 40;
  localparam int ring_depth = 16;

  logic        wb_clk_i = 1'b0;
  logic        soft_reset;
  logic        start_i;
  logic        crash_i;
  logic [15:0] crash_src_i;
  logic [15:0] crash_val_i;
  logic        event_vld_i;
  logic [14:0] event_dat_i;
  logic [5:0]  lc_rd_adr_i;
  logic [5:0]  acm_rd_adr_i;
  logic [15:0] mem_dat_i = '0;
  logic        mem_ack_i = 1'b0;
  logic        mem_err_i;
  wire         done_o;
  wire  [11:0] lc_thresh_o;
  wire  [15:0] acm_quad_o;
  wire  [15:0] sysconfig_o;
  wire         mem_cyc_o;
  wire         mem_we_o;
  wire  [15:0] mem_adr_o;
  wire  [15:0] mem_dat_o;

  int          rec_crash[$];
  int          rec_src[$];
  int          rec_val[$];
  int          rec_events[$];
  int          rec_sys[$];
  int          rec_seed[$];
  int          rec_dly[$];
  int          max_dly_all = 0;
  int          cycle_limit = 0;
  int          cycle_cnt   = 0;
  int          rst_cycle   = 0;
  int          chk_cnt     = 0;
  int          err_cnt     = 0;
  logic [15:0] cur_seed      = '0;
  logic [15:0] cur_sysconfig = '0;
  int          max_dly       = 0;
  int          ack_dly       = 0;
  int          wait_cnt      = 0;
  int          flash_wr_cnt  = 0;
  int          bad_wr_cnt    = 0;
  logic [15:0] flash_mem [64];
  logic [14:0] ring_q[$];  // events the ring should hold, oldest first

  boot_loader_top #(
    .LC_COUNT   (lc_count),
    .ACM_COUNT  (acm_count),
    .RING_DEPTH (ring_depth)
  ) u_dut (
    .wb_clk_i     (wb_clk_i),
    .soft_reset   (soft_reset),
    .start_i      (start_i),
    .crash_i      (crash_i),
    .done_o       (done_o),
    .crash_src_i  (crash_src_i),
    .crash_val_i  (crash_val_i),
    .event_vld_i  (event_vld_i),
    .event_dat_i  (event_dat_i),
    .lc_rd_adr_i  (lc_rd_adr_i),
    .acm_rd_adr_i (acm_rd_adr_i),
    .lc_thresh_o  (lc_thresh_o),
    .acm_quad_o   (acm_quad_o),
    .sysconfig_o  (sysconfig_o),
    .mem_cyc_o    (mem_cyc_o),
    .mem_we_o     (mem_we_o),
    .mem_adr_o    (mem_adr_o),
    .mem_dat_o    (mem_dat_o),
    .mem_dat_i    (mem_dat_i),
    .mem_ack_i    (mem_ack_i),
    .mem_err_i    (mem_err_i)
  );

  always #2 wb_clk_i = ~wb_clk_i;

  // FROM image rule
  function automatic logic [7:0] lc_byte(input logic [15:0] seed, input int n);
    lc_byte = 8'(int'(seed) + 7 * n);
  endfunction

  function automatic logic [15:0] acm_word(input logic [15:0] seed, input int n);
    acm_word = 16'(int'(seed) * 3 + n);
  endfunction

  function automatic logic [15:0] image_word(input logic [15:0] adr);
    if (adr == flash_sysconfig_a) begin
      return cur_sysconfig;
    end
    if (adr >= from_lc_a && adr < from_lc_a + 16'(lc_count)) begin
      return 16'(lc_byte(cur_seed, int'(adr - from_lc_a)));
    end
    if (adr - from_acm_a < 16'(acm_count)) begin
      return acm_word(cur_seed, int'(adr - from_acm_a));
    end
    return 16'h0000;
  endfunction

  // FROM and flash model, acks after 0..max_dly cycles
  always @(posedge wb_clk_i) begin
    if (mem_ack_i) begin
      mem_ack_i <= 1'b0;
    end else if (mem_cyc_o) begin
      if (wait_cnt >= ack_dly) begin
        mem_ack_i <= 1'b1;
        wait_cnt = 0;
        ack_dly  = int'($urandom_range(max_dly, 0));
        if (!mem_we_o) begin
          mem_dat_i <= image_word(mem_adr_o);
        end else if (mem_adr_o >= flash_a && mem_adr_o < flash_a + 16'd64) begin
          flash_mem[6'(mem_adr_o - flash_a)] = mem_dat_o;
          flash_wr_cnt++;
        end else begin
          $display("Error: memory write to unmapped address %h", mem_adr_o);
          bad_wr_cnt++;
        end
      end else begin
        wait_cnt++;
      end
    end
  end

  // 400 bus cycles per run, each at most delay+4 clocks
  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Error: timeout, the run did not end within %0d cycles", cycle_cnt);
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic load_records();
    int    fd;
    int    c, s, v, e, w, y, d;
    string line;
    fd = $fopen("sim/boot_input.dat", "r");
    if (fd == 0) begin
      $display("Error: cannot open sim/boot_input.dat");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%h %h %h %h %h %h %h", c, s, v, e, w, y, d) == 7) begin
          rec_crash.push_back(c);
          rec_src.push_back(s);
          rec_val.push_back(v);
          rec_events.push_back(e);
          rec_sys.push_back(w);
          rec_seed.push_back(y);
          rec_dly.push_back(d);
          if (d > max_dly_all) begin
            max_dly_all = d;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic inject_events(input int n);
    logic [14:0] ev;
    for (int i = 0; i < n; i++) begin
      ev = 15'($urandom);
      @(posedge wb_clk_i);
      event_vld_i <= 1'b1;
      event_dat_i <= ev;
      ring_q.push_back(ev);
      if (ring_q.size() > ring_depth) begin
        void'(ring_q.pop_front());  // oldest falls out
      end
    end
    @(posedge wb_clk_i);
    event_vld_i <= 1'b0;
  endtask

  task automatic run_record(input int i);
    logic [14:0] dump_q[$];
    int          wr_start;
    int          n_words;
    logic [47:0] dump_time;
    logic [7:0]  b;
    cur_seed      = 16'(rec_seed[i]);
    cur_sysconfig = 16'(rec_sys[i]);
    max_dly       = rec_dly[i];
    ack_dly       = int'($urandom_range(max_dly, 0));
    $display("Record %0d: crash %0d, %0d events", i, rec_crash[i], rec_events[i]);
    inject_events(rec_events[i]);
    if (rec_crash[i] != 0) begin
      dump_q = ring_q;
      ring_q.delete();  // the dump drains the ring
    end
    wr_start = flash_wr_cnt;
    for (int k = 0; k < 64; k++) begin
      flash_mem[k] = '0;
    end
    @(posedge wb_clk_i);
    crash_src_i <= 16'(rec_src[i]);
    crash_val_i <= 16'(rec_val[i]);
    crash_i     <= (rec_crash[i] != 0);
    @(posedge wb_clk_i);
    start_i <= 1'b1;
    @(posedge wb_clk_i);
    start_i <= 1'b0;
    @(posedge wb_clk_i);
    check_val("done_o during run", 16'(done_o), 16'h0000);
    @(posedge wb_clk_i);
    start_i <= 1'b1;  // must be ignored
    @(posedge wb_clk_i);
    start_i <= 1'b0;
    while (!done_o) begin
      @(posedge wb_clk_i);
    end
    @(posedge wb_clk_i);
    crash_i <= 1'b0;
    for (int n = 0; n < lc_count; n++) begin
      @(posedge wb_clk_i);
      lc_rd_adr_i  <= 6'(n);
      acm_rd_adr_i <= 6'(n % acm_count);
      @(posedge wb_clk_i);
      b = lc_byte(cur_seed, n);
      check_val($sformatf("lc_thresh_o[%0d]", n), 16'(lc_thresh_o),
                (b == 8'hff) ? 16'h0fff : {4'h0, b, 4'h0});
      if (n < acm_count) begin
        check_val($sformatf("acm_quad_o[%0d]", n), acm_quad_o, acm_word(cur_seed, n));
      end
    end
    check_val("sysconfig_o", sysconfig_o, (cur_sysconfig > 16'h00ff) ? 16'h0000 : cur_sysconfig);
    if (rec_crash[i] != 0) begin
      n_words = (dump_q.size() == 0) ? 1 : dump_q.size();
      check_val("flash write count", 16'(flash_wr_cnt - wr_start), 16'(6 + n_words));
      check_val("flash[0] marker", flash_mem[0], dump_marker);
      dump_time = {flash_mem[3], flash_mem[2], flash_mem[1]};
      if (dump_time >= 48'(cycle_cnt - rst_cycle)) begin
        err_cnt++;
        $display("Error: dump time %h is not below the elapsed cycle count %0h",
                 dump_time, cycle_cnt - rst_cycle);
      end
      check_val("flash[4] crash source", flash_mem[4], 16'(rec_src[i]));
      check_val("flash[5] crash value", flash_mem[5], 16'(rec_val[i]));
      if (dump_q.size() == 0) begin
        check_val("flash[6] empty ring", flash_mem[6], 16'h8000);
      end
      for (int k = 0; k < dump_q.size(); k++) begin
        check_val($sformatf("flash[%0d] event", 6 + k), flash_mem[6'(6 + k)],
                  {k == dump_q.size() - 1, dump_q[k]});
      end
      inject_events(2);  // checked by the next dump
    end else begin
      check_val("flash write count", 16'(flash_wr_cnt - wr_start), 16'h0000);
    end
    check_val("unmapped memory writes", 16'(bad_wr_cnt), 16'h0000);
  endtask

  initial begin
    void'($urandom(90570));
    soft_reset   <= 1'b1;
    start_i      <= 1'b0;
    crash_i      <= 1'b0;
    crash_src_i  <= '0;
    crash_val_i  <= '0;
    event_vld_i  <= 1'b0;
    event_dat_i  <= '0;
    lc_rd_adr_i  <= '0;
    acm_rd_adr_i <= '0;
    mem_err_i    <= 1'b0;
    load_records();
    if (rec_crash.size() == 0) begin
      $display("Error: no test records were read from sim/boot_input.dat");
      $display("Finished with errors");
      $finish;
    end else begin
      cycle_limit = rec_crash.size() * 400 * (max_dly_all + 6);
      repeat (8) @(posedge wb_clk_i);
      soft_reset <= 1'b0;
      rst_cycle = cycle_cnt;
      @(posedge wb_clk_i);
      check_val("done_o after reset", 16'(done_o), 16'h0001);
      check_val("sysconfig_o after reset", sysconfig_o, 16'h0000);
      for (int i = 0; i < rec_crash.size(); i++) begin
        run_record(i);
      end
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim/boot_input.dat */
# crash  crash_src  crash_val  events  sysconfig_word  image_seed  max_ack_delay
# all columns hex, one record per run in file order
1 0002 0bad 00 0042 0011 0
1 0003 1234 05 00ff 00a5 2
0 0000 0000 03 ffff 0080 3
1 0007 beef 14 0100 0033 1
1 0001 0001 00 0012 00f0 4
0 0000 0000 0a 0000 0048 0
1 000c c0de 02 00fe 0071 2

/* list.f */
logic/boot_pkg.sv
logic/wb_if.sv
logic/event_ring.sv
logic/ctrl_regs.sv
logic/dma_engine.sv
logic/wb_addr_decoder.sv
logic/boot_loader_top.sv
sim/tb_boot_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the boot loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f list.f \
  --top-module tb_boot_loader -o tb_boot_loader > build.log 2>&1 &&
  ./obj_dir/tb_boot_loader > sim.log 2>&1 ||
  { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "PASS" ||
  { echo "FAIL: no result line in sim.log"; exit 1; }
